// ==== fir_macros.svh ====
// Sizes and coefficient values for the 30-tap symmetric FIR filter.
// Included by the package and by every module that needs a size or a coefficient.
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// sample and arithmetic width, all sums wrap here
`define FIR_DW 18

// taps in the delay line and the unique coefficients of the symmetric set
`define FIR_TAPS 30
`define FIR_UNIQ 15

// taps plus the output register
`define FIR_VALID_DEPTH 31

// coefficient k weights the pair sum of tap k and tap 29-k
`define FIR_COEFF_0 (88)
`define FIR_COEFF_1 (0)
`define FIR_COEFF_2 (-97)
`define FIR_COEFF_3 (-197)
`define FIR_COEFF_4 (-294)
`define FIR_COEFF_5 (-380)
`define FIR_COEFF_6 (-447)
`define FIR_COEFF_7 (-490)
`define FIR_COEFF_8 (-504)
`define FIR_COEFF_9 (-481)
`define FIR_COEFF_10 (-420)
`define FIR_COEFF_11 (-319)
`define FIR_COEFF_12 (-178)
`define FIR_COEFF_13 (0)
`define FIR_COEFF_14 (212)

`endif

// ==== fir_pkg.sv ====
// Data types shared by the FIR filter modules.
// Modules refer to these as fir_pkg::name.
`default_nettype none

`include "fir_macros.svh"

package fir_pkg;

	// ************************************************************************
	// sample and word types
	// ************************************************************************

	// one signed sample, also used for every wrapped sum and product
	typedef logic signed [`FIR_DW-1:0] sample_t;

	// whole delay line, stage 0 is the newest sample
	typedef sample_t [`FIR_TAPS-1:0] tap_window_t;

	// one wrapped product per mirror pair
	typedef sample_t [`FIR_UNIQ-1:0] product_bank_t;

endpackage

`default_nettype wire

// ==== fir_shift_reg.sv ====
// Enabled shift register with every stage visible on the output.
// The element type is a parameter, so one module serves samples and valid bits.
`timescale 1ns/1ps
`default_nettype none

module fir_shift_reg #(
	parameter type T = logic,
	parameter int DEPTH = 2
) (
	input  wire logic       i_clk,
	input  wire logic       i_reset,
	input  wire logic       i_clk_ena,
	input  wire T           i_data,
	output T [DEPTH-1:0]    o_taps
);

	// stage 0 takes the input, higher stages are older
	T [DEPTH-1:0] stages;

	// ************************************************************************
	// shift chain
	// ************************************************************************

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			stages <= '0;
		end else if (i_clk_ena) begin
			stages <= {stages[DEPTH-2:0], i_data};
		end
	end

	assign o_taps = stages;

	// ************************************************************************
	// checks
	// ************************************************************************

	// a low enable freezes the whole chain for that edge
	a_hold_when_disabled: assert property (
		@(posedge i_clk) disable iff (i_reset)
		!i_clk_ena |=> $stable(stages)
	) else $error("shift register moved with clock enable low");

endmodule

`default_nettype wire

// ==== fir_tap_products.sv ====
// Symmetric pre-adders and fixed coefficient multipliers of the FIR filter.
// Purely combinational; turns the tap window into one product per mirror pair.
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_tap_products (
	input  wire fir_pkg::tap_window_t i_taps,
	output fir_pkg::product_bank_t    o_products
);

	// coefficient k belongs to taps k and 29-k
	localparam fir_pkg::sample_t COEFF [`FIR_UNIQ] = '{
		`FIR_COEFF_0,
		`FIR_COEFF_1,
		`FIR_COEFF_2,
		`FIR_COEFF_3,
		`FIR_COEFF_4,
		`FIR_COEFF_5,
		`FIR_COEFF_6,
		`FIR_COEFF_7,
		`FIR_COEFF_8,
		`FIR_COEFF_9,
		`FIR_COEFF_10,
		`FIR_COEFF_11,
		`FIR_COEFF_12,
		`FIR_COEFF_13,
		`FIR_COEFF_14
	};

	// ************************************************************************
	// pre-add and multiply per mirror pair
	// ************************************************************************

	for (genvar k = 0; k < `FIR_UNIQ; k++) begin : g_pair
		fir_pkg::sample_t pair_sum;
		fir_pkg::sample_t product;

		// wraps in 18 bits, no growth bit
		assign pair_sum = i_taps[k] + i_taps[`FIR_TAPS-1-k];

		// 18-bit context keeps only the low half of the full product
		assign product = pair_sum * COEFF[k];

		assign o_products[k] = product;
	end

endmodule

`default_nettype wire

// ==== fir_adder_tree.sv ====
// Balanced adder tree over the 15 tap products, followed by the output register.
// All levels are combinational; the register loads only on enabled edges.
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_adder_tree (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   i_clk_ena,
	input  wire fir_pkg::product_bank_t i_products,
	output fir_pkg::sample_t            o_out
);

	// level widths shrink 15 -> 8 -> 4 -> 2 -> 1
	fir_pkg::sample_t [7:0] sum_l1;
	fir_pkg::sample_t [3:0] sum_l2;
	fir_pkg::sample_t [1:0] sum_l3;
	fir_pkg::sample_t       sum_l4;

	// ************************************************************************
	// tree levels
	// ************************************************************************

	always_comb begin
		// level 1, seven pairs and the odd product passed straight up
		for (int i = 0; i < 7; i++) begin
			sum_l1[i] = i_products[2*i] + i_products[2*i+1];
		end
		sum_l1[7] = i_products[`FIR_UNIQ-1];

		// level 2
		for (int i = 0; i < 4; i++) begin
			sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
		end

		// level 3
		for (int i = 0; i < 2; i++) begin
			sum_l3[i] = sum_l2[2*i] + sum_l2[2*i+1];
		end

		// level 4, final wrapped sum
		sum_l4 = sum_l3[0] + sum_l3[1];
	end

	// ************************************************************************
	// output register
	// ************************************************************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_out <= '0;
		end else if (i_clk_ena) begin
			o_out <= sum_l4;
		end
	end

	// output stays put across an edge with the enable low
	a_out_hold: assert property (
		@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(o_out)
	) else $error("o_out changed with clock enable low");

endmodule

`default_nettype wire

// ==== fir_top.sv ====
// Top level of the 30-tap symmetric FIR filter.
// Sample delay line, pair products and adder tree, plus a matching valid delay.
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_top (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             i_clk_ena,
	input  wire logic             i_valid,
	input  wire fir_pkg::sample_t i_in,
	output logic                  o_valid,
	output fir_pkg::sample_t      o_out
);

	fir_pkg::tap_window_t           taps;
	fir_pkg::product_bank_t         products;
	logic [`FIR_VALID_DEPTH-1:0]    valid_taps;

	// ************************************************************************
	// data path
	// ************************************************************************

	// last 30 enabled samples, stage 0 newest
	fir_shift_reg #(
		.T     (fir_pkg::sample_t),
		.DEPTH (`FIR_TAPS)
	) i_sample_delay (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_clk_ena (i_clk_ena),
		.i_data    (i_in),
		.o_taps    (taps)
	);

	fir_tap_products i_tap_products (
		.i_taps     (taps),
		.o_products (products)
	);

	fir_adder_tree i_adder_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_out      (o_out)
	);

	// ************************************************************************
	// valid path
	// ************************************************************************

	// one stage deeper than the taps to cover the output register
	fir_shift_reg #(
		.T     (logic),
		.DEPTH (`FIR_VALID_DEPTH)
	) i_valid_delay (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_clk_ena (i_clk_ena),
		.i_data    (i_valid),
		.o_taps    (valid_taps)
	);

	assign o_valid = valid_taps[`FIR_VALID_DEPTH-1];

endmodule

`default_nettype wire

// ==== tb_fir_top.sv ====
// Testbench for the 30-tap symmetric FIR filter top level.
// Runs reset, an impulse, a full-range random stream and random enable gaps.
// Concurrent assertions compare the DUT against an independent model.
`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module tb_fir_top;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int COEFFS [15] = '{
		88, 0, -97, -197, -294, -380, -447, -490,
		-504, -481, -420, -319, -178, 0, 212
	};

	logic             clk;
	logic             reset;
	logic             i_clk_ena;
	logic             i_valid;
	fir_pkg::sample_t i_in;
	logic             o_valid;
	fir_pkg::sample_t o_out;

	// model state, hist[0] is the newest sample
	logic signed [17:0]            hist [0:`FIR_TAPS-1];
	logic [`FIR_VALID_DEPTH-1:0]   vhist;
	logic signed [17:0]            exp_out;
	logic signed [17:0]            last_out;
	logic                          last_valid;
	logic                          imp_mode;
	int                            imp_age;
	int                            cycles;
	integer                        seed;

	fir_top i_fir_top (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	always #4 clk = ~clk;

	// ************************************************************************
	// helpers
	// ************************************************************************

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_mismatch(input string sig, input int expected, input int actual);
		$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, sig, expected, actual);
		abort_run();
	endtask

	// weight seen by tap j, symmetric around the middle
	function automatic int tap_weight(input int j);
		return (j < 15) ? COEFFS[j] : COEFFS[29 - j];
	endfunction

	// pair sums, products and total all wrap in 18 bits
	function automatic logic signed [17:0] expected_output();
		logic signed [17:0] acc;
		logic signed [17:0] pair;
		logic signed [35:0] full;
		acc = '0;
		for (int k = 0; k < 15; k++) begin
			pair = hist[k] + hist[29 - k];
			full = pair * COEFFS[k];
			acc = acc + full[17:0];
		end
		return acc;
	endfunction

	task automatic drive_cycle(input logic ena, input logic valid, input fir_pkg::sample_t data);
		@(negedge clk);
		i_clk_ena = ena;
		i_valid = valid;
		i_in = data;
	endtask

	// enable high about 60% of the time
	function automatic logic random_enable();
		logic [31:0] r;
		r = $random(seed);
		return (r % 10) >= 4;
	endfunction

	// random valid bit and full-range sample for one cycle
	task automatic drive_random(input logic ena);
		logic [31:0] r_valid;
		logic [31:0] r_data;
		r_valid = $random(seed);
		r_data = $random(seed);
		drive_cycle(ena, r_valid[0], r_data[`FIR_DW-1:0]);
	endtask

	// ************************************************************************
	// reference model
	// ************************************************************************

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `FIR_TAPS; i++) begin
				hist[i] <= '0;
			end
			vhist <= '0;
			exp_out <= '0;
			imp_age <= 0;
		end else if (i_clk_ena) begin
			exp_out <= expected_output();
			for (int i = 1; i < `FIR_TAPS; i++) begin
				hist[i] <= hist[i - 1];
			end
			hist[0] <= i_in;
			vhist <= {vhist[`FIR_VALID_DEPTH-2:0], i_valid};
			// edges since the impulse was taken in
			if (imp_mode && i_in == 1) begin
				imp_age <= 1;
			end else if (imp_age != 0 && imp_age < 40) begin
				imp_age <= imp_age + 1;
			end else begin
				imp_age <= 0;
			end
		end
	end

	// outputs from the previous edge, for the hold check
	always @(posedge clk) begin
		last_out <= o_out;
		last_valid <= o_valid;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	// ************************************************************************
	// checks
	// ************************************************************************

	a_reset_out: assert property (@(posedge clk) reset |-> o_out == 0)
		else report_mismatch("o_out", 0, $sampled(o_out));

	a_reset_valid: assert property (@(posedge clk) reset |-> o_valid == 0)
		else report_mismatch("o_valid", 0, $sampled(o_valid));

	a_out_model: assert property (@(posedge clk) disable iff (reset) o_out == exp_out)
		else report_mismatch("o_out", $sampled(exp_out), $sampled(o_out));

	// valid sample reaches the end of the 31-stage history
	a_valid_model: assert property (@(posedge clk) disable iff (reset)
		o_valid == vhist[`FIR_VALID_DEPTH-1])
		else report_mismatch("o_valid", $sampled(vhist[`FIR_VALID_DEPTH-1]), $sampled(o_valid));

	// the impulse shows on o_out one enabled edge after it enters a tap
	a_impulse_taps: assert property (@(posedge clk) disable iff (reset)
		(imp_age >= 2 && imp_age <= 31) |-> o_out == tap_weight(imp_age - 2))
		else report_mismatch("o_out", tap_weight($sampled(imp_age) - 2), $sampled(o_out));

	a_impulse_tail: assert property (@(posedge clk) disable iff (reset)
		(imp_age > 31) |-> o_out == 0)
		else report_mismatch("o_out", 0, $sampled(o_out));

	a_hold_out: assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> o_out == last_out)
		else report_mismatch("o_out", $sampled(last_out), $sampled(o_out));

	a_hold_valid: assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> o_valid == last_valid)
		else report_mismatch("o_valid", $sampled(last_valid), $sampled(o_valid));

	// ************************************************************************
	// stimulus
	// ************************************************************************

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		imp_mode = 1'b0;
		cycles = 0;
		seed = 31;

		// reset held over four rising edges
		#1;
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// idle after reset, nothing enabled yet
		repeat (3) drive_cycle(1'b0, 1'b0, '0);

		// single unit sample, then zeros until the response dies out
		drive_cycle(1'b1, 1'b1, 18'sd1);
		imp_mode = 1'b1;
		drive_cycle(1'b1, 1'b0, '0);
		imp_mode = 1'b0;
		repeat (40) drive_cycle(1'b1, 1'b0, '0);

		// full-range stream, wraps freely
		repeat (300) drive_random(1'b1);

		// enable low about 40% of the time
		repeat (300) drive_random(random_enable());

		// flush the delay lines
		repeat (40) drive_cycle(1'b1, 1'b0, '0);
		repeat (2) @(posedge clk);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fir_top.f ====
+incdir+.
fir_pkg.sv
fir_shift_reg.sv
fir_tap_products.sv
fir_adder_tree.sv
fir_top.sv
tb_fir_top.sv

// ==== Bender.yml ====
package:
  name: fir_top

sources:
  - include_dirs:
      - .
    files:
      - fir_pkg.sv
      - fir_shift_reg.sv
      - fir_tap_products.sv
      - fir_adder_tree.sv
      - fir_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fir_top.sv
